/* include/adc_capture_settings.svh */
`ifndef ADC_CAPTURE_SETTINGS_SVH
`define ADC_CAPTURE_SETTINGS_SVH

// sample and word widths
`define ADC_SAMPLE_W      12
`define WORD_W            64

// FIFO depths, powers of two
`define SAMPLE_FIFO_DEPTH 1024
`define WORD_FIFO_DEPTH   64

// counter widths
`define PRESAMPLE_W       10
`define SAMPLE_CNT_W      20
`define DOWNSAMPLE_W      8

`endif

/* src/adc_capture_pkg.sv */
`default_nettype none
`include "adc_capture_settings.svh"

package adc_capture_pkg;

    typedef logic [`ADC_SAMPLE_W-1:0] sample_t;
    typedef logic [`WORD_W-1:0]       word_t;
    typedef logic [`PRESAMPLE_W-1:0]  presample_cnt_t;
    typedef logic [`SAMPLE_CNT_W-1:0] sample_cnt_t;
    typedef logic [`DOWNSAMPLE_W-1:0] downsample_t;   // samples skipped between kept ones

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRESAMP_FILLING,
        ST_PRESAMP_FULL,
        ST_TRIGGERED,
        ST_DONE
    } capture_state_e;

    typedef struct packed {
        presample_cnt_t presamples;
        sample_cnt_t    samples;       // total kept, presamples included
        downsample_t    downsample;
    } capture_cfg_t;

    typedef struct packed {
        logic sample_overflow;
        logic presamp_error;
        logic downsample_error;
    } error_stat_t;

endpackage

`default_nettype wire

/* src/capture_counters.sv */
`default_nettype none
`include "adc_capture_settings.svh"

module capture_counters (
    input  wire logic                          adc_sampleclk,
    input  wire logic                          reset,
    input  wire logic                          arm_pulse_i,
    input  wire logic                          trig_edge_i,
    input  wire adc_capture_pkg::capture_cfg_t cfg_i,
    input  wire logic                          wr_en_i,
    input  wire logic                          restart_i,
    output logic                               keep_o,
    output logic                               presamp_full_o,
    output logic                               last_sample_o
);

    adc_capture_pkg::downsample_t    ds_q;
    adc_capture_pkg::presample_cnt_t presamp_q;
    adc_capture_pkg::sample_cnt_t    sample_q;
    adc_capture_pkg::sample_cnt_t    sample_next;

    // the trigger edge always keeps its sample and realigns the decimation
    assign keep_o = trig_edge_i || (ds_q == cfg_i.downsample);

    assign presamp_full_o = (presamp_q == cfg_i.presamples);

    // at the trigger write the total restarts from the presamples held
    assign sample_next = restart_i ? adc_capture_pkg::sample_cnt_t'(presamp_q) + 1'b1
                                   : sample_q + 1'b1;

    assign last_sample_o = wr_en_i && (sample_next == cfg_i.samples);

    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_pulse_i) begin
            ds_q      <= '0;
            presamp_q <= '0;
            sample_q  <= '0;
        end else begin
            if (keep_o)
                ds_q <= '0;
            else
                ds_q <= ds_q + 1'b1;

            if (wr_en_i) begin
                sample_q <= sample_next;
                if (!presamp_full_o)
                    presamp_q <= presamp_q + 1'b1;   // saturates at P
            end
        end
    end

endmodule

`default_nettype wire

/* src/capture_fsm.sv */
`default_nettype none
`include "adc_capture_settings.svh"

module capture_fsm (
    input  wire logic                          adc_sampleclk,
    input  wire logic                          reset,
    input  wire logic                          arm_i,
    input  wire logic                          trig_i,
    input  wire adc_capture_pkg::capture_cfg_t cfg_i,
    input  wire logic                          keep_i,
    input  wire logic                          presamp_full_i,
    input  wire logic                          last_sample_i,
    input  wire logic                          sample_empty_i,
    input  wire logic                          word_full_i,
    output logic                               arm_pulse_o,
    output logic                               trig_edge_o,
    output logic                               restart_o,
    output logic                               sample_wr_o,
    output logic                               sample_rd_o,
    output logic                               pack_en_o,
    output logic                               armed_o,
    output logic                               capture_done_o,
    output logic                               presamp_error_o,
    output logic                               downsample_error_o
);

    adc_capture_pkg::capture_state_e state_q;
    logic arm_q;
    logic trig_q;
    logic arm_det;
    logic waiting;
    logic wr_stop;   // all N samples written, only draining remains
    logic drain;

    assign arm_det     = arm_i && !arm_q;
    assign trig_edge_o = trig_i && !trig_q;

    assign waiting = (state_q == adc_capture_pkg::ST_IDLE && armed_o) ||
                     (state_q == adc_capture_pkg::ST_PRESAMP_FILLING) ||
                     (state_q == adc_capture_pkg::ST_PRESAMP_FULL);

    assign restart_o = trig_edge_o && waiting;

    always_comb begin
        case (state_q)
            adc_capture_pkg::ST_IDLE:            sample_wr_o = restart_o;
            adc_capture_pkg::ST_PRESAMP_FILLING: sample_wr_o = keep_i;
            adc_capture_pkg::ST_PRESAMP_FULL:    sample_wr_o = keep_i;
            adc_capture_pkg::ST_TRIGGERED:       sample_wr_o = keep_i && !wr_stop;
            default:                             sample_wr_o = 1'b0;
        endcase
    end

    // once P samples sit in the FIFO every new one pushes the oldest out
    assign drain = keep_i && !restart_o &&
                   ((state_q == adc_capture_pkg::ST_PRESAMP_FULL) ||
                    (state_q == adc_capture_pkg::ST_PRESAMP_FILLING && presamp_full_i));

    assign pack_en_o   = (state_q == adc_capture_pkg::ST_TRIGGERED) &&
                         !sample_empty_i && !word_full_i;
    assign sample_rd_o = drain || pack_en_o;

    assign presamp_error_o = restart_o && !presamp_full_i &&
                             (state_q == adc_capture_pkg::ST_PRESAMP_FILLING);

    assign capture_done_o = (state_q == adc_capture_pkg::ST_DONE);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state_q            <= adc_capture_pkg::ST_IDLE;
            arm_q              <= 1'b0;
            trig_q             <= 1'b0;
            arm_pulse_o        <= 1'b0;
            armed_o            <= 1'b0;
            wr_stop            <= 1'b0;
            downsample_error_o <= 1'b0;
        end else begin
            arm_q       <= arm_i;
            trig_q      <= trig_i;
            arm_pulse_o <= arm_det;
            // decimation cannot be combined with presamples
            downsample_error_o <= arm_pulse_o && (cfg_i.downsample != '0) &&
                                  (cfg_i.presamples != '0);

            if (arm_det) begin
                state_q <= adc_capture_pkg::ST_IDLE;   // abandon any capture in progress
                armed_o <= 1'b0;
            end else if (arm_pulse_o) begin
                armed_o <= 1'b1;
                wr_stop <= 1'b0;
                if (cfg_i.presamples != '0)
                    state_q <= adc_capture_pkg::ST_PRESAMP_FILLING;
                else
                    state_q <= adc_capture_pkg::ST_IDLE;   // wait for trigger
            end else begin
                case (state_q)
                    adc_capture_pkg::ST_IDLE,
                    adc_capture_pkg::ST_PRESAMP_FILLING,
                    adc_capture_pkg::ST_PRESAMP_FULL: begin
                        if (restart_o) begin
                            state_q <= adc_capture_pkg::ST_TRIGGERED;
                            wr_stop <= last_sample_i;
                        end else if (state_q == adc_capture_pkg::ST_PRESAMP_FILLING &&
                                     presamp_full_i) begin
                            state_q <= adc_capture_pkg::ST_PRESAMP_FULL;
                        end
                    end
                    adc_capture_pkg::ST_TRIGGERED: begin
                        if (last_sample_i)
                            wr_stop <= 1'b1;
                        if (wr_stop && sample_empty_i) begin
                            state_q <= adc_capture_pkg::ST_DONE;
                            armed_o <= 1'b0;
                        end
                    end
                    default: ;   // done holds until the next arm
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/sync_fifo.sv */
`default_nettype none
`include "adc_capture_settings.svh"

module sync_fifo #(
    parameter int WIDTH = `ADC_SAMPLE_W,
    parameter int DEPTH = `SAMPLE_FIFO_DEPTH   // power of two
) (
    input  wire logic             adc_sampleclk,
    input  wire logic             reset,
    input  wire logic             clear_i,
    input  wire logic             wr_i,
    input  wire logic [WIDTH-1:0] data_i,
    input  wire logic             rd_i,
    output logic      [WIDTH-1:0] data_o,
    output logic                  empty_o,
    output logic                  full_o,
    output logic                  overflow_o
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_wr;
    logic             do_rd;

    assign empty_o = (count == '0);
    assign full_o  = count[AW];                // count reached DEPTH
    assign data_o  = mem[rd_ptr];              // fall-through head

    assign do_rd      = rd_i && !empty_o;
    assign do_wr      = wr_i && (!full_o || do_rd);
    assign overflow_o = wr_i && !do_wr;        // write lost

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr] <= data_i;
    end

endmodule

`default_nettype wire

/* src/word_packer.sv */
`default_nettype none
`include "adc_capture_settings.svh"

module word_packer (
    input  wire logic                     adc_sampleclk,
    input  wire logic                     reset,
    input  wire logic                     clear_i,
    input  wire logic                     sample_valid_i,
    input  wire adc_capture_pkg::sample_t sample_i,
    output logic                          word_valid_o,
    output adc_capture_pkg::word_t        word_o
);

    // 16 samples fill 3 words: 6 samples, then 5, then 5
    localparam int SHIFT_W = 6 * `ADC_SAMPLE_W;

    logic [SHIFT_W-1:0]     shift_q;
    logic [SHIFT_W-1:0]     shift_next;
    logic [1:0]             phase_q;   // word position within the 16-sample cycle
    logic [2:0]             cnt_q;     // samples taken in this word
    logic                   word_end;
    adc_capture_pkg::word_t word_win;

    assign shift_next = {shift_q[SHIFT_W-`ADC_SAMPLE_W-1:0], sample_i};
    assign word_end   = (cnt_q == ((phase_q == 2'd0) ? 3'd5 : 3'd4));

    // leftover bits from the previous word sit above the window
    always_comb begin
        case (phase_q)
            2'd0:    word_win = shift_next[71:8];
            2'd1:    word_win = shift_next[67:4];   // 8 bits carried over
            default: word_win = shift_next[63:0];   // 4 bits carried over
        endcase
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i) begin
            phase_q      <= '0;
            cnt_q        <= '0;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= sample_valid_i && word_end;
            if (sample_valid_i) begin
                if (word_end) begin
                    cnt_q   <= '0;
                    phase_q <= (phase_q == 2'd2) ? 2'd0 : phase_q + 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (sample_valid_i) begin
            shift_q <= shift_next;
            if (word_end)
                word_o <= word_win;
        end
    end

endmodule

`default_nettype wire

/* src/error_status.sv */
`default_nettype none
`include "adc_capture_settings.svh"

module error_status (
    input  wire logic                    adc_sampleclk,
    input  wire logic                    reset,
    input  wire logic                    arm_pulse_i,
    input  wire logic                    sample_overflow_i,
    input  wire logic                    presamp_error_i,
    input  wire logic                    downsample_error_i,
    output adc_capture_pkg::error_stat_t error_stat_o,
    output logic                         error_flag_o
);

    adc_capture_pkg::error_stat_t events;
    adc_capture_pkg::error_stat_t stat_next;

    assign events = '{sample_overflow:  sample_overflow_i,
                      presamp_error:    presamp_error_i,
                      downsample_error: downsample_error_i};

    assign stat_next = error_stat_o | events;   // new events never clear old ones

    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_pulse_i) begin
            error_stat_o <= '0;
            error_flag_o <= 1'b0;
        end else begin
            error_stat_o <= stat_next;
            error_flag_o <= |stat_next;   // tracks the flags in the same cycle
        end
    end

endmodule

`default_nettype wire

/* src/adc_capture_top.sv */
`default_nettype none
`include "adc_capture_settings.svh"

module adc_capture_top (
    input  wire logic                          adc_sampleclk,
    input  wire logic                          reset,
    input  wire adc_capture_pkg::sample_t      adc_data_i,
    input  wire logic                          arm_i,
    input  wire logic                          trig_i,
    input  wire adc_capture_pkg::capture_cfg_t cfg_i,
    input  wire logic                          word_rd_i,
    output adc_capture_pkg::word_t             word_o,
    output logic                               word_empty_o,
    output logic                               armed_o,
    output logic                               capture_done_o,
    output adc_capture_pkg::error_stat_t       error_stat_o,
    output logic                               error_flag_o
);

    logic arm_pulse;
    logic trig_edge;
    logic restart;
    logic keep;
    logic presamp_full;
    logic last_sample;
    logic sample_wr;
    logic sample_rd;
    logic sample_empty;
    logic sample_overflow;
    logic pack_en;
    logic word_full;
    logic word_valid;
    logic presamp_error;
    logic downsample_error;

    adc_capture_pkg::sample_t sample_head;
    adc_capture_pkg::word_t   packed_word;

    capture_fsm u_capture_fsm (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .arm_i              (arm_i),
        .trig_i             (trig_i),
        .cfg_i              (cfg_i),
        .keep_i             (keep),
        .presamp_full_i     (presamp_full),
        .last_sample_i      (last_sample),
        .sample_empty_i     (sample_empty),
        .word_full_i        (word_full),
        .arm_pulse_o        (arm_pulse),
        .trig_edge_o        (trig_edge),
        .restart_o          (restart),
        .sample_wr_o        (sample_wr),
        .sample_rd_o        (sample_rd),
        .pack_en_o          (pack_en),
        .armed_o            (armed_o),
        .capture_done_o     (capture_done_o),
        .presamp_error_o    (presamp_error),
        .downsample_error_o (downsample_error)
    );

    capture_counters u_capture_counters (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .arm_pulse_i    (arm_pulse),
        .trig_edge_i    (trig_edge),
        .cfg_i          (cfg_i),
        .wr_en_i        (sample_wr),
        .restart_i      (restart),
        .keep_o         (keep),
        .presamp_full_o (presamp_full),
        .last_sample_o  (last_sample)
    );

    sync_fifo #(
        .WIDTH (`ADC_SAMPLE_W),
        .DEPTH (`SAMPLE_FIFO_DEPTH)
    ) u_sample_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (arm_pulse),
        .wr_i          (sample_wr),
        .data_i        (adc_data_i),
        .rd_i          (sample_rd),
        .data_o        (sample_head),
        .empty_o       (sample_empty),
        .full_o        (),
        .overflow_o    (sample_overflow)
    );

    word_packer u_word_packer (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .clear_i        (arm_pulse),
        .sample_valid_i (pack_en),
        .sample_i       (sample_head),
        .word_valid_o   (word_valid),
        .word_o         (packed_word)
    );

    sync_fifo #(
        .WIDTH (`WORD_W),
        .DEPTH (`WORD_FIFO_DEPTH)
    ) u_word_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .clear_i       (arm_pulse),
        .wr_i          (word_valid),
        .data_i        (packed_word),
        .rd_i          (word_rd_i),
        .data_o        (word_o),
        .empty_o       (word_empty_o),
        .full_o        (word_full),
        .overflow_o    ()
    );

    error_status u_error_status (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .arm_pulse_i        (arm_pulse),
        .sample_overflow_i  (sample_overflow),
        .presamp_error_i    (presamp_error),
        .downsample_error_i (downsample_error),
        .error_stat_o       (error_stat_o),
        .error_flag_o       (error_flag_o)
    );

endmodule

`default_nettype wire

/* sim/tb_adc_capture.sv */
`default_nettype none
`include "adc_capture_settings.svh"

module tb_adc_capture;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W_ARMED   = 0;
    localparam int W_DONE    = 1;
    localparam int W_EMPTY   = 2;
    localparam int W_PRE_ERR = 3;
    localparam int W_DS_ERR  = 4;

    logic                          adc_sampleclk;
    logic                          reset;
    adc_capture_pkg::sample_t      adc_data_i;
    logic                          arm_i;
    logic                          trig_i;
    adc_capture_pkg::capture_cfg_t cfg_i;
    logic                          word_rd_i;
    adc_capture_pkg::word_t        word_o;
    logic                          word_empty_o;
    logic                          armed_o;
    logic                          capture_done_o;
    adc_capture_pkg::error_stat_t  error_stat_o;
    logic                          error_flag_o;

    logic [31:0] data_rng;
    logic [31:0] ctrl_rng;   // reader gaps and scenario parameters
    logic        read_en;
    logic        trig_prev;
    int          trig_cycle;   // edge index of the last trigger edge

    adc_capture_pkg::sample_t hist[$];   // adc_data_i as sampled at each edge
    adc_capture_pkg::word_t   got_words[$];

    adc_capture_top i_dut (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .adc_data_i     (adc_data_i),
        .arm_i          (arm_i),
        .trig_i         (trig_i),
        .cfg_i          (cfg_i),
        .word_rd_i      (word_rd_i),
        .word_o         (word_o),
        .word_empty_o   (word_empty_o),
        .armed_o        (armed_o),
        .capture_done_o (capture_done_o),
        .error_stat_o   (error_stat_o),
        .error_flag_o   (error_flag_o)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #5 adc_sampleclk = ~adc_sampleclk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        ctrl_rng = lcg_step(ctrl_rng);
        return lo + int'(ctrl_rng[30:16]) % (hi - lo + 1);
    endfunction

    // ADC source and monitor, one new sample every cycle
    initial begin
        data_rng   = 32'hb94c;
        adc_data_i = '0;
        trig_prev  = 1'b0;
        trig_cycle = 0;
        forever begin
            @(posedge adc_sampleclk);
            hist.push_back(adc_data_i);
            if (trig_i && !trig_prev)
                trig_cycle = hist.size() - 1;
            trig_prev = trig_i;
            data_rng = lcg_step(data_rng);
            adc_data_i <= data_rng[27:16];
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // one clock edge, records a pop and picks the next read strobe
    task automatic tick();
        @(posedge adc_sampleclk);
        if (word_rd_i && !word_empty_o)
            got_words.push_back(word_o);
        ctrl_rng = lcg_step(ctrl_rng);
        word_rd_i <= read_en && (ctrl_rng[18:16] >= 3'd2);   // about one gap in four
    endtask

    function automatic logic watched(input int sel);
        case (sel)
            W_ARMED:   return armed_o;
            W_DONE:    return capture_done_o;
            W_EMPTY:   return word_empty_o;
            W_PRE_ERR: return error_stat_o.presamp_error;
            default:   return error_stat_o.downsample_error;
        endcase
    endfunction

    task automatic wait_high(input int sel, input int limit, input string what);
        int n;
        n = 0;
        while (!watched(sel)) begin
            tick();
            n++;
            if (n > limit)
                fail_run($sformatf("timeout after %0d cycles waiting for %s", limit, what));
        end
    endtask

    task automatic arm_capture(input int p, input int n, input int d);
        cfg_i.presamples <= adc_capture_pkg::presample_cnt_t'(p);
        cfg_i.samples    <= adc_capture_pkg::sample_cnt_t'(n);
        cfg_i.downsample <= adc_capture_pkg::downsample_t'(d);
        arm_i <= 1'b1;
        tick();
        arm_i <= 1'b0;
        tick();   // armed_o is low here even if a capture was running
        wait_high(W_ARMED, 20, "armed_o after the arm edge");
        check_value("capture_done_o", capture_done_o, 1'b0);
        check_value("error_stat_o", error_stat_o, 3'b000);   // flags cleared by the arm
        check_value("error_flag_o", error_flag_o, 1'b0);
        got_words.delete();   // word FIFO was emptied by the arm
    endtask

    task automatic pulse_trigger();
        trig_i <= 1'b1;
        repeat (3) tick();
        trig_i <= 1'b0;
    endtask

    task automatic run_capture(input int wait_cycles, input int stall_cycles);
        read_en = (stall_cycles == 0);
        repeat (wait_cycles) tick();
        pulse_trigger();
        repeat (stall_cycles) tick();
        read_en = 1'b1;
        wait_high(W_DONE, 40000, "capture_done_o");
        wait_high(W_EMPTY, 4000, "the word FIFO to drain");
    endtask

    // sample k of the bit stream read back from the DUT
    function automatic adc_capture_pkg::sample_t got_sample(input int k);
        adc_capture_pkg::sample_t s;
        adc_capture_pkg::word_t   w;
        int pos;
        for (int i = 0; i < `ADC_SAMPLE_W; i++) begin
            pos = k * `ADC_SAMPLE_W + i;
            w = got_words[pos / `WORD_W];
            s[`ADC_SAMPLE_W-1-i] = w[`WORD_W-1 - pos % `WORD_W];
        end
        return s;
    endfunction

    // expected words: kept samples around the trigger, MSB first, tail dropped
    task automatic check_capture(input int p, input int n, input int d);
        adc_capture_pkg::word_t   exp_word;
        adc_capture_pkg::sample_t s;
        int nwords;
        int pos;
        nwords = (n * `ADC_SAMPLE_W) / `WORD_W;
        check_value("word count", got_words.size(), nwords);
        for (int w = 0; w < nwords; w++) begin
            for (int b = 0; b < `WORD_W; b++) begin
                pos = w * `WORD_W + b;
                s = hist[trig_cycle + (pos / `ADC_SAMPLE_W - p) * (d + 1)];
                exp_word[`WORD_W-1-b] = s[`ADC_SAMPLE_W-1 - pos % `ADC_SAMPLE_W];
            end
            check_value("word_o", got_words[w], exp_word);
        end
    endtask

    initial begin
        int p;
        int n;
        int d;
        reset     = 1'b1;
        arm_i     = 1'b0;
        trig_i    = 1'b0;
        cfg_i     = '0;
        word_rd_i = 1'b0;
        read_en   = 1'b0;
        ctrl_rng  = ~32'hb94c;
        repeat (10) tick();
        reset <= 1'b0;
        repeat (2) tick();
        check_value("armed_o", armed_o, 1'b0);
        check_value("capture_done_o", capture_done_o, 1'b0);
        check_value("error_flag_o", error_flag_o, 1'b0);
        check_value("word_empty_o", word_empty_o, 1'b1);

        // plain capture of whole 16-sample groups
        n = 16 * rand_range(1, 20);
        arm_capture(0, n, 0);
        run_capture(rand_range(5, 50), 0);
        check_value("word count", got_words.size(), 3 * n / 16);
        check_capture(0, n, 0);
        check_value("error_stat_o", error_stat_o, 3'b000);

        // presamples, trigger well after the FIFO holds them
        p = rand_range(1, 100);
        n = p + rand_range(32, 200);
        arm_capture(p, n, 0);
        run_capture(p + rand_range(10, 40), 0);
        for (int k = 0; k < p; k++)
            check_value("presample", got_sample(k), hist[trig_cycle - p + k]);
        check_capture(p, n, 0);
        check_value("error_stat_o", error_stat_o, 3'b000);

        // decimation with a trailing partial word
        d = rand_range(1, 7);
        n = 16 * rand_range(2, 8) + rand_range(1, 15);
        arm_capture(0, n, d);
        run_capture(rand_range(5, 50), 0);
        check_capture(0, n, d);
        check_value("downsample_error", error_stat_o.downsample_error, 1'b0);

        // error flags
        arm_capture(rand_range(50, 100), 200, 0);
        repeat (10) tick();
        pulse_trigger();   // presamples not yet full
        wait_high(W_PRE_ERR, 20, "presamp_error");
        check_value("error_flag_o", error_flag_o, 1'b1);
        arm_capture(5, 100, 3);
        wait_high(W_DS_ERR, 20, "downsample_error");
        check_value("error_flag_o", error_flag_o, 1'b1);
        arm_capture(0, 16, 0);   // clears every flag
        repeat (5) tick();
        check_value("error_stat_o", error_stat_o, 3'b000);

        // reader stalls until the sample FIFO overflows
        arm_capture(0, 2000, 0);
        run_capture(20, 1600);
        check_value("sample_overflow", error_stat_o.sample_overflow, 1'b1);
        check_value("error_flag_o", error_flag_o, 1'b1);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* adc_capture.f */
+incdir+include
src/adc_capture_pkg.sv
src/capture_counters.sv
src/capture_fsm.sv
src/sync_fifo.sv
src/word_packer.sv
src/error_status.sv
src/adc_capture_top.sv
sim/tb_adc_capture.sv

/* Bender.yml */
package:
  name: adc_capture

sources:
  - include_dirs:
      - include
    files:
      - src/adc_capture_pkg.sv
      - src/capture_counters.sv
      - src/capture_fsm.sv
      - src/sync_fifo.sv
      - src/word_packer.sv
      - src/error_status.sv
      - src/adc_capture_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_adc_capture.sv
